/* da_cfg_pkg.sv */
`default_nettype none

package da_cfg_pkg;

	// ****************************************
	// datapath types
	// ****************************************

	// types are sized for the largest tap count and smaller filters use the low bits
	localparam int TAPS_MAX = 4;

	// one bit per tap where tap k drives address bit k
	typedef logic [TAPS_MAX-1:0] lut_addr_t;

	// one precomputed partial sum of the coefficients
	typedef logic signed [11:0] lut_word_t;

	// filter output with headroom for the shifted partial sums
	typedef logic signed [23:0] result_t;

	// strobes from the sequencer to the datapath
	typedef struct packed {
		logic load_taps;
		logic clear_acc;
		logic read_lut;
		logic accumulate;
		logic capture;
	} step_t;

endpackage

`default_nettype wire

/* da_bus_pkg.sv */
`default_nettype none

package da_bus_pkg;

	// ****************************************
	// APB transfer structs
	// ****************************************

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// busy sits in the top bit of the status register
	typedef struct packed {
		logic busy;
		logic done;
		logic table_lock;
	} status_t;

	// register map
	localparam logic [7:0] REG_SAMPLE   = 8'h00;
	localparam logic [7:0] REG_STATUS   = 8'h04;
	localparam logic [7:0] REG_RESULT   = 8'h08;
	localparam logic [7:0] REG_LUT_BASE = 8'h40;
	localparam logic [7:0] REG_LUT_LAST = 8'h7C;

endpackage

`default_nettype wire

/* da_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module da_apb_regs import da_bus_pkg::*, da_cfg_pkg::*; #(
	parameter int DATA_W = 8,
	parameter int TAPS   = 4
) (
	input  wire               clk,
	input  wire               resetn,
	input  wire apb_req_t     apb_req,
	output apb_rsp_t          apb_rsp,
	input  wire               busy,
	input  wire               done,
	input  wire result_t      result,
	output logic              lut_we,
	output lut_addr_t         lut_waddr,
	output lut_word_t         lut_wdata,
	output logic              sample_valid,
	output logic [DATA_W-1:0] sample,
	output logic              result_read
);

	localparam int LUT_DEPTH = 1 << TAPS;

	logic    access;
	logic    wr_access;
	logic    rd_access;
	logic    hit_sample;
	logic    hit_status;
	logic    hit_result;
	logic    hit_lut;
	logic    bad_access;
	status_t status;

	assign access    = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite;
	assign rd_access = access && !apb_req.pwrite;

	// ****************************************
	// address decode
	// ****************************************

	assign hit_sample = apb_req.paddr == REG_SAMPLE;
	assign hit_status = apb_req.paddr == REG_STATUS;
	assign hit_result = apb_req.paddr == REG_RESULT;
	// only word entries that exist for the configured tap count
	assign hit_lut = apb_req.paddr >= REG_LUT_BASE && apb_req.paddr <= REG_LUT_LAST &&
		apb_req.paddr[1:0] == 2'b00 && int'(apb_req.paddr[5:2]) < LUT_DEPTH;

	// a table write while the filter runs is refused like any access to a hole in the map
	assign bad_access = apb_req.pwrite ? !(hit_sample || (hit_lut && !busy)) :
		!(hit_status || hit_result);

	assign status = '{busy: busy, done: done, table_lock: busy};

	assign lut_we       = wr_access && hit_lut && !busy;
	assign lut_waddr    = lut_addr_t'(apb_req.paddr[5:2]);
	assign lut_wdata    = lut_word_t'(apb_req.pwdata[11:0]);
	assign sample_valid = wr_access && hit_sample && !busy;
	assign result_read  = rd_access && hit_result;

	// the sequencer loads the taps one cycle after acceptance, so the sample is held here
	always_ff @(posedge clk) begin
		if (sample_valid) begin
			sample <= apb_req.pwdata[DATA_W-1:0];
		end
	end

	always_comb begin
		apb_rsp.prdata = '0;
		if (rd_access && hit_status) begin
			apb_rsp.prdata = 32'(status);
		end else if (rd_access && hit_result) begin
			apb_rsp.prdata = 32'(result);
		end
		// a new sample waits in the access phase until the running one is finished
		apb_rsp.pready  = !(wr_access && hit_sample && busy);
		apb_rsp.pslverr = access && bad_access;
	end

	a_err_in_access: assert property (@(posedge clk) disable iff (!resetn)
		!access |-> !(apb_rsp.pready && apb_rsp.pslverr));

endmodule

`default_nettype wire

/* da_control.sv */
`timescale 1ns/1ps
`default_nettype none

module da_control import da_cfg_pkg::*; (
	input  wire   clk,
	input  wire   resetn,
	input  wire   sample_valid,
	input  wire   result_read,
	input  wire   last_bit,
	output step_t step,
	output logic  bit_start,
	output logic  bit_advance,
	output logic  busy,
	output logic  done
);

	// drain covers the accumulate that trails the last table read
	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD,
		S_READ,
		S_DRAIN,
		S_FINISH
	} state_t;

	state_t state;
	logic   acc_pending;

	// ****************************************
	// sequencer
	// ****************************************

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state       <= S_IDLE;
			acc_pending <= 1'b0;
			done        <= 1'b0;
		end else begin
			// the table answers one cycle after each read
			acc_pending <= state == S_READ;
			case (state)
				S_IDLE: begin
					if (sample_valid) begin
						state <= S_LOAD;
					end
				end
				S_LOAD:   state <= S_READ;
				S_READ: begin
					if (last_bit) begin
						state <= S_DRAIN;
					end
				end
				S_DRAIN:  state <= S_FINISH;
				S_FINISH: state <= S_IDLE;
				default:  state <= S_IDLE;
			endcase
			if (state == S_FINISH) begin
				done <= 1'b1;
			end else if (sample_valid || result_read) begin
				done <= 1'b0;
			end
		end
	end

	assign step = '{
		load_taps:  state == S_LOAD,
		clear_acc:  state == S_LOAD,
		read_lut:   state == S_READ,
		accumulate: acc_pending,
		capture:    state == S_FINISH
	};

	assign bit_start   = state == S_LOAD;
	assign bit_advance = state == S_READ && !last_bit;
	assign busy        = state != S_IDLE;

	a_load_then_read: assert property (@(posedge clk) disable iff (!resetn)
		step.load_taps |-> !step.read_lut ##1 step.read_lut);

	a_busy_after_capture: assert property (@(posedge clk) disable iff (!resetn)
		$fell(busy) |-> $past(step.capture));

endmodule

`default_nettype wire

/* da_bit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module da_bit_counter #(
	parameter int DATA_W = 8
) (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire                        bit_start,
	input  wire                        bit_advance,
	output logic [$clog2(DATA_W)-1:0]  bit_index,
	output logic                       last_bit,
	output logic                       sign_bit
);

	localparam int IDX_W = $clog2(DATA_W);
	localparam logic [IDX_W-1:0] LAST = IDX_W'(DATA_W - 1);

	always_ff @(posedge clk) begin
		if (!resetn || bit_start) begin
			bit_index <= '0;
		end else if (bit_advance && !last_bit) begin
			bit_index <= bit_index + 1'b1;
		end
	end

	assign last_bit = bit_index == LAST;
	// two's complement samples carry their sign in the top bit
	assign sign_bit = last_bit;

	a_index_range: assert property (@(posedge clk) disable iff (!resetn)
		bit_index <= LAST);

endmodule

`default_nettype wire

/* da_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module da_lut import da_cfg_pkg::*; #(
	parameter int TAPS = 4
) (
	input  wire            clk,
	input  wire            we,
	input  wire lut_addr_t waddr,
	input  wire lut_word_t wdata,
	input  wire            re,
	input  wire lut_addr_t raddr,
	output lut_word_t      rdata
);

	localparam int DEPTH = 1 << TAPS;

	// entry a holds the sum of the coefficients whose tap bit is set in a
	lut_word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr[TAPS-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[raddr[TAPS-1:0]];
		end
	end

	// host writes only happen while the sequencer is idle
	a_no_rw_overlap: assert property (@(posedge clk)
		we |-> !re);

endmodule

`default_nettype wire

/* da_tap_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module da_tap_shift import da_cfg_pkg::*; #(
	parameter int DATA_W = 8,
	parameter int TAPS   = 4
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       load,
	input  wire [DATA_W-1:0]          sample,
	input  wire [$clog2(DATA_W)-1:0]  bit_index,
	output lut_addr_t                 addr
);

	// tap 0 holds the newest sample
	logic [DATA_W-1:0] taps [TAPS];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int k = 0; k < TAPS; k++) begin
				taps[k] <= '0;
			end
		end else if (load) begin
			taps[0] <= sample;
			for (int k = 1; k < TAPS; k++) begin
				taps[k] <= taps[k-1];
			end
		end
	end

	// ****************************************
	// bit slice across the taps
	// ****************************************

	always_comb begin
		addr = '0;
		for (int k = 0; k < TAPS; k++) begin
			addr[k] = taps[k][bit_index];
		end
	end

endmodule

`default_nettype wire

/* da_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module da_accumulator import da_cfg_pkg::*; #(
	parameter int DATA_W = 8
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire step_t                step,
	input  wire [$clog2(DATA_W)-1:0]  bit_index,
	input  wire                       sign_bit,
	input  wire lut_word_t            lut_word,
	output result_t                   result
);

	localparam int IDX_W = $clog2(DATA_W);

	logic [IDX_W-1:0] index_d;
	logic             sign_d;
	result_t          acc;
	result_t          term;

	// table data lags its address by one cycle so the bit position follows it
	always_ff @(posedge clk) begin
		if (!resetn) begin
			index_d <= '0;
			sign_d  <= 1'b0;
		end else begin
			index_d <= bit_index;
			sign_d  <= sign_bit;
		end
	end

	assign term = result_t'(lut_word) <<< index_d;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			acc    <= '0;
			result <= '0;
		end else begin
			if (step.clear_acc) begin
				acc <= '0;
			end else if (step.accumulate) begin
				// the sign bit weighs minus two to the power of its position
				acc <= sign_d ? acc - term : acc + term;
			end
			if (step.capture) begin
				result <= acc;
			end
		end
	end

endmodule

`default_nettype wire

/* da_filter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module da_filter_top import da_bus_pkg::*, da_cfg_pkg::*; #(
	parameter int DATA_W = 8,
	parameter int TAPS   = 4
) (
	input  wire           clk,
	input  wire           resetn,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp
);

	localparam int IDX_W = $clog2(DATA_W);

	logic              busy;
	logic              done;
	result_t           result;
	logic              lut_we;
	lut_addr_t         lut_waddr;
	lut_word_t         lut_wdata;
	logic              sample_valid;
	logic [DATA_W-1:0] sample;
	logic              result_read;
	step_t             step;
	logic              bit_start;
	logic              bit_advance;
	logic [IDX_W-1:0]  bit_index;
	logic              last_bit;
	logic              sign_bit;
	lut_addr_t         lut_raddr;
	lut_word_t         lut_rdata;

	// ****************************************
	// host side
	// ****************************************

	da_apb_regs #(.DATA_W(DATA_W), .TAPS(TAPS)) u_regs (
		.clk(clk), .resetn(resetn), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.busy(busy), .done(done), .result(result),
		.lut_we(lut_we), .lut_waddr(lut_waddr), .lut_wdata(lut_wdata),
		.sample_valid(sample_valid), .sample(sample), .result_read(result_read)
	);

	da_control u_control (
		.clk(clk), .resetn(resetn), .sample_valid(sample_valid),
		.result_read(result_read), .last_bit(last_bit), .step(step),
		.bit_start(bit_start), .bit_advance(bit_advance), .busy(busy), .done(done)
	);

	// ****************************************
	// bit-serial datapath
	// ****************************************

	da_bit_counter #(.DATA_W(DATA_W)) u_counter (
		.clk(clk), .resetn(resetn), .bit_start(bit_start), .bit_advance(bit_advance),
		.bit_index(bit_index), .last_bit(last_bit), .sign_bit(sign_bit)
	);

	da_tap_shift #(.DATA_W(DATA_W), .TAPS(TAPS)) u_taps (
		.clk(clk), .resetn(resetn), .load(step.load_taps), .sample(sample),
		.bit_index(bit_index), .addr(lut_raddr)
	);

	da_lut #(.TAPS(TAPS)) u_lut (
		.clk(clk), .we(lut_we), .waddr(lut_waddr), .wdata(lut_wdata),
		.re(step.read_lut), .raddr(lut_raddr), .rdata(lut_rdata)
	);

	da_accumulator #(.DATA_W(DATA_W)) u_acc (
		.clk(clk), .resetn(resetn), .step(step), .bit_index(bit_index),
		.sign_bit(sign_bit), .lut_word(lut_rdata), .result(result)
	);

endmodule

`default_nettype wire

/* da_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module da_tb import da_bus_pkg::*, da_cfg_pkg::*; ();

	localparam int DATA_W     = 8;
	localparam int TAPS       = 4;
	localparam int WAIT_LIMIT = 200;

	logic     clk;
	logic     resetn;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	// coefficients in tap order where tap 0 weighs the newest sample
	int      coef [TAPS] = '{57, -23, 118, -91};
	int      ref_taps [TAPS];
	result_t exp_q [$];
	result_t act_q [$];
	int      err_count;
	int      test_errors;
	int      tests_passed;
	int      tests_failed;

	da_filter_top #(.DATA_W(DATA_W), .TAPS(TAPS)) UUT (
		.clk(clk), .resetn(resetn), .apb_req(apb_req), .apb_rsp(apb_rsp)
	);

	always #2 clk = ~clk;

	// ****************************************
	// reference model
	// ****************************************

	// entry a is the sum of the coefficients whose tap bit is set in a
	function automatic lut_word_t lut_entry(int a);
		int sum;
		sum = 0;
		for (int k = 0; k < TAPS; k++) begin
			if (a[k]) begin
				sum += coef[k];
			end
		end
		return lut_word_t'(sum);
	endfunction

	// shifts a sample into the model's delay line and returns the filter output
	function automatic result_t reference_step(int s);
		int sum;
		for (int k = TAPS - 1; k > 0; k--) begin
			ref_taps[k] = ref_taps[k-1];
		end
		ref_taps[0] = s;
		sum = 0;
		for (int k = 0; k < TAPS; k++) begin
			sum += coef[k] * ref_taps[k];
		end
		return result_t'(sum);
	endfunction

	// ****************************************
	// checks and reporting
	// ****************************************

	task automatic check_result(string name, result_t expected, result_t actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			err_count++;
		end
	endtask

	task automatic check_status(string name, status_t expected, status_t actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s expected %b actual %b", $time, name, expected, actual);
			err_count++;
		end
	endtask

	task automatic report_problem(string what);
		$display("ERROR t=%0t %s", $time, what);
		err_count++;
	endtask

	task automatic give_up(string what);
		$display("timeout t=%0t %s", $time, what);
		$display("TB FAILED");
		$finish;
	endtask

	// pairs each result read over the bus with the oldest expected value
	always @(negedge clk) begin
		if (act_q.size() > 0) begin
			if (exp_q.size() == 0) begin
				report_problem("a result was read with no sample pending");
				void'(act_q.pop_front());
			end else begin
				check_result("result", exp_q.pop_front(), act_q.pop_front());
			end
		end
	end

	// ****************************************
	// APB master
	// ****************************************

	// starts at a falling edge and returns at the falling edge after completion
	task automatic apb_transfer(logic write, logic [7:0] addr, logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr, output int waits);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		waits = 0;
		#1;
		while (!apb_rsp.pready) begin
			if (waits == WAIT_LIMIT) begin
				give_up("APB transfer never saw pready");
			end
			waits++;
			@(negedge clk);
			#1;
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge clk);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_write(logic [7:0] addr, logic [31:0] wdata, output logic slverr,
		output int waits);
		logic [31:0] rdata;
		apb_transfer(1'b1, addr, wdata, rdata, slverr, waits);
	endtask

	task automatic apb_read(logic [7:0] addr, output logic [31:0] rdata, output logic slverr);
		int waits;
		apb_transfer(1'b0, addr, '0, rdata, slverr, waits);
	endtask

	// ****************************************
	// sequences
	// ****************************************

	task automatic send_sample(int s, result_t expected, output int waits);
		logic err;
		apb_write(REG_SAMPLE, 32'(s), err, waits);
		if (err) begin
			report_problem("sample write returned pslverr");
		end
		exp_q.push_back(expected);
	endtask

	task automatic wait_done();
		logic [31:0] rdata;
		logic        err;
		status_t     st;
		int          polls;
		polls = 0;
		st = '0;
		while (!st.done) begin
			if (polls == WAIT_LIMIT) begin
				give_up("STATUS.done never rose");
			end
			polls++;
			apb_read(REG_STATUS, rdata, err);
			if (err) begin
				report_problem("status read returned pslverr");
			end
			st = status_t'(rdata[2:0]);
		end
	endtask

	task automatic read_result();
		logic [31:0] rdata;
		logic        err;
		apb_read(REG_RESULT, rdata, err);
		if (err) begin
			report_problem("result read returned pslverr");
		end
		act_q.push_back(result_t'(rdata[23:0]));
	endtask

	task automatic run_sample(int s);
		int waits;
		send_sample(s, reference_step(s), waits);
		wait_done();
		read_result();
	endtask

	task automatic drain_compare();
		int n;
		n = 0;
		while (act_q.size() > 0) begin
			if (n == WAIT_LIMIT) begin
				give_up("result comparison never caught up");
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic finish_test(string name);
		drain_compare();
		if (err_count == test_errors) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_count - test_errors);
		end
		test_errors = err_count;
	endtask

	// the model's delay line clears with the DUT and pending results are lost
	task automatic apply_reset();
		resetn = 1'b0;
		for (int k = 0; k < TAPS; k++) begin
			ref_taps[k] = 0;
		end
		exp_q.delete();
		repeat (4) @(negedge clk);
		resetn = 1'b1;
	endtask

	initial begin
		logic [31:0] rdata;
		logic        err;
		int          waits;
		int          s;
		clk = 1'b0;
		apb_req = '0;
		err_count = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(86));
		apply_reset();

		for (int a = 0; a < (1 << TAPS); a++) begin
			apb_write(REG_LUT_BASE + 8'(4 * a), 32'(lut_entry(a)), err, waits);
			if (err) begin
				report_problem("table write while idle returned pslverr");
			end
		end
		// a single 1 walks through the taps and picks out one coefficient each time
		for (int k = 0; k < TAPS; k++) begin
			s = (k == 0) ? 1 : 0;
			void'(reference_step(s));
			send_sample(s, result_t'(coef[k]), waits);
			wait_done();
			read_result();
		end
		finish_test("1 impulse response");

		for (int n = 0; n < 40; n++) begin
			s = int'($urandom_range((1 << DATA_W) - 1)) - (1 << (DATA_W - 1));
			if (n == 13) begin
				s = -(1 << (DATA_W - 1));
			end
			run_sample(s);
		end
		finish_test("2 random stream");

		s = 45;
		send_sample(s, reference_step(s), waits);
		apb_read(REG_STATUS, rdata, err);
		check_status("status after sample write", status_t'{busy: 1'b1, done: 1'b0,
			table_lock: 1'b1}, status_t'(rdata[2:0]));
		// this read sees the state one cycle before done
		repeat (DATA_W - 1) @(negedge clk);
		apb_read(REG_STATUS, rdata, err);
		check_status("status before done", status_t'{busy: 1'b1, done: 1'b0,
			table_lock: 1'b1}, status_t'(rdata[2:0]));
		wait_done();
		read_result();
		s = -77;
		send_sample(s, reference_step(s), waits);
		repeat (DATA_W + 2) @(negedge clk);
		apb_read(REG_STATUS, rdata, err);
		check_status("status at done", status_t'{busy: 1'b0, done: 1'b1,
			table_lock: 1'b0}, status_t'(rdata[2:0]));
		read_result();
		apb_read(REG_STATUS, rdata, err);
		check_status("status after result read", '0, status_t'(rdata[2:0]));
		finish_test("3 status and timing");

		s = 99;
		send_sample(s, reference_step(s), waits);
		s = -100;
		send_sample(s, reference_step(s), waits);
		if (waits != DATA_W + 2) begin
			report_problem($sformatf("second sample write waited %0d cycles", waits));
		end
		// the first result is still in the result register
		read_result();
		wait_done();
		read_result();
		finish_test("4 back-pressure");

		s = 64;
		send_sample(s, reference_step(s), waits);
		apb_write(REG_LUT_BASE + 8'h0C, 32'h0000_07FF, err, waits);
		if (!err) begin
			report_problem("table write during busy did not return pslverr");
		end
		wait_done();
		read_result();
		// all-ones samples hit the entry that the refused write aimed at
		run_sample(-1);
		run_sample(-1);
		for (int n = 0; n < 4; n++) begin
			run_sample(int'($urandom_range((1 << DATA_W) - 1)) - (1 << (DATA_W - 1)));
		end
		apb_read(8'h20, rdata, err);
		if (!err) begin
			report_problem("read of unmapped address 0x20 did not return pslverr");
		end
		apb_write(8'h24, 32'h1, err, waits);
		if (!err) begin
			report_problem("write to unmapped address 0x24 did not return pslverr");
		end
		finish_test("5 table lock and bus errors");

		s = 120;
		send_sample(s, reference_step(s), waits);
		repeat (3) @(negedge clk);
		apply_reset();
		apb_read(REG_RESULT, rdata, err);
		check_result("result after reset", '0, result_t'(rdata[23:0]));
		apb_read(REG_STATUS, rdata, err);
		check_status("status after reset", '0, status_t'(rdata[2:0]));
		run_sample(-57);
		run_sample(33);
		finish_test("6 reset retention");

		$display("tests passed %0d failed %0d, check errors %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
da_cfg_pkg.sv
da_bus_pkg.sv
da_apb_regs.sv
da_control.sv
da_bit_counter.sv
da_lut.sv
da_tap_shift.sv
da_accumulator.sv
da_filter_top.sv
da_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module da_tb -f build.f -o da_sim

out=$(./obj_dir/da_sim)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
